/* include/pid_config.svh */
`ifndef PID_CONFIG_SVH
`define PID_CONFIG_SVH

////////////////////////////////////////////////////////////////////////
// data path widths
////////////////////////////////////////////////////////////////////////

`define PID_W_IN          18   // adc sample width
`define PID_W_OUT         32   // core arithmetic width
`define PID_W_DAC         16   // dac word width

////////////////////////////////////////////////////////////////////////
// filter and core timing
////////////////////////////////////////////////////////////////////////

`define PID_OS_LOG2       2    // log2 of samples per block, 4 samples
`define PID_COMP_LATENCY  1    // cycles spent in COMPUTE

`endif

/* run.sh */
#!/bin/sh
# compile with Verilator, run, and pass only when the testbench reports success
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f sources.f --top-module tb_pid_lock -o tb_pid_lock \
	&& ./obj_dir/tb_pid_lock | tee /dev/stderr | grep "^TEST PASS$" > /dev/null \
	&& echo "simulation passed" \
	|| { echo "simulation failed"; exit 1; }

/* sources.f */
+incdir+include
src/pid_data_pkg.sv
src/pid_ctrl_pkg.sv
src/oversample_filter.sv
src/param_regs.sv
src/pid_core.sv
src/source_mux.sv
src/pid_lock_top.sv
tests/tb_pid_lock.sv

/* src/oversample_filter.sv */
`timescale 1ns/10ps
`include "pid_config.svh"

module oversample_filter
	import pid_data_pkg::*;
(
	input  logic        clk_in,     // system clock
	input  logic        pid_reset,  // sync reset, active high

	input  adc_sample_t adc_data,   // raw adc sample
	input  logic        adc_valid,  // one sample per high cycle

	output pid_word_t   avg_data,   // block average held until next block
	output logic        avg_valid   // single cycle pulse per block
);

	////////////////////////////////////////////////////////////////////////
	// block accumulator
	////////////////////////////////////////////////////////////////////////

	logic [`PID_OS_LOG2-1:0] smp_cnt;   // samples taken in current block
	pid_word_t               acc;       // running sum of the block
	pid_word_t               smp_ext;   // sample widened to core width
	pid_word_t               blk_sum;   // sum including this sample
	logic                    blk_last;  // this sample closes the block

	assign smp_ext  = pid_word_t'(adc_data);  // sign extend
	assign blk_sum  = acc + smp_ext;
	assign blk_last = adc_valid && (&smp_cnt);  // counter at 2^n - 1

	always_ff @(posedge clk_in) begin
		if (pid_reset) begin
			smp_cnt <= '0;
			acc     <= '0;
		end else if (adc_valid) begin
			smp_cnt <= smp_cnt + 1'b1;  // wraps at block end
			if (blk_last) begin
				acc <= '0;  // fresh block
			end else begin
				acc <= blk_sum;
			end
		end
	end

	////////////////////////////////////////////////////////////////////////
	// average output
	////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk_in) begin
		if (pid_reset) begin
			avg_valid <= 1'b0;
		end else begin
			avg_valid <= blk_last;  // pulse one cycle after last sample
		end
	end

	// payload loads on the closing sample
	always_ff @(posedge clk_in) begin
		if (blk_last) begin
			avg_data <= blk_sum >>> `PID_OS_LOG2;  // arithmetic shift keeps sign
		end
	end

	////////////////////////////////////////////////////////////////////////
	// checks
	////////////////////////////////////////////////////////////////////////

	// downstream core counts on a one cycle strobe
	assert property (@(posedge clk_in) disable iff (pid_reset)
		avg_valid |=> !avg_valid)
	else $error("avg_valid held high for more than one cycle");

endmodule

/* src/param_regs.sv */
`timescale 1ns/10ps

module param_regs
	import pid_ctrl_pkg::*;
(
	input  logic  clk_in,        // system clock
	input  logic  pid_reset,     // sync reset, active high

	input  logic  param_req,     // host request, four phase
	input  coef_t setpoint_in,   // host setpoint
	input  coef_t p_coef_in,     // host proportional gain
	input  coef_t i_coef_in,     // host integral gain
	input  coef_t d_coef_in,     // host derivative gain
	output logic  param_ack,     // acknowledge to host

	output coef_t stg_setpoint,  // staged setpoint
	output coef_t stg_p,         // staged proportional gain
	output coef_t stg_i,         // staged integral gain
	output coef_t stg_d          // staged derivative gain
);

	////////////////////////////////////////////////////////////////////////
	// ack machine with param_ack as the state bit
	////////////////////////////////////////////////////////////////////////

	param_set_t stg;      // staged parameter set
	logic       capture;  // new request seen while idle
	logic       release_ack;  // host has dropped req

	assign capture     = param_req && !param_ack;   // phase 1 -> 2
	assign release_ack = !param_req && param_ack;   // phase 3 -> 4

	always_ff @(posedge clk_in) begin
		if (pid_reset) begin
			param_ack <= 1'b0;
		end else if (capture) begin
			param_ack <= 1'b1;
		end else if (release_ack) begin
			param_ack <= 1'b0;
		end
	end

	////////////////////////////////////////////////////////////////////////
	// staging registers
	////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk_in) begin
		if (pid_reset) begin
			stg <= '0;  // zero gains until host writes
		end else if (capture) begin
			stg.setpoint <= setpoint_in;  // host holds values while req high
			stg.p        <= p_coef_in;
			stg.i        <= i_coef_in;
			stg.d        <= d_coef_in;
		end
	end

	assign stg_setpoint = stg.setpoint;
	assign stg_p        = stg.p;
	assign stg_i        = stg.i;
	assign stg_d        = stg.d;

	////////////////////////////////////////////////////////////////////////
	// checks
	////////////////////////////////////////////////////////////////////////

	// host waits for ack to drop before the next request
	assert property (@(posedge clk_in) disable iff (pid_reset)
		$rose(param_req) |-> !param_ack)
	else $error("param_req rose while param_ack was still high");

endmodule

/* src/pid_core.sv */
`timescale 1ns/10ps
`include "pid_config.svh"

module pid_core
	import pid_data_pkg::*;
	import pid_ctrl_pkg::*;
(
	input  logic      clk_in,      // system clock
	input  logic      pid_reset,   // sync reset, active high

	input  pid_word_t data,        // filtered sample
	input  logic      data_valid,  // filtered sample strobe

	input  coef_t     setpoint,    // staged setpoint
	input  coef_t     p_coef,      // staged proportional gain
	input  coef_t     i_coef,      // staged integral gain
	input  coef_t     d_coef,      // staged derivative gain

	input  logic      lock_en,     // low holds core in reset
	input  logic      clear,       // zero error history and last output
	input  logic      update_en,   // arms the update pulse
	input  logic      update,      // load staged params into active set

	output pid_word_t pid_data,    // controller output
	output logic      pid_valid    // high in SEND only
);

	////////////////////////////////////////////////////////////////////////
	// internal state
	////////////////////////////////////////////////////////////////////////

	localparam logic [7:0] COMP_LAST = 8'(`PID_COMP_LATENCY - 1);  // last COMPUTE cycle

	logic       core_rst;     // local reset, also while unlocked
	pid_word_t  data_q;       // latched input sample
	param_set_t act;          // active parameter set

	pid_word_t  sp_ext;       // widened setpoint
	pid_word_t  p_ext;        // widened gains
	pid_word_t  i_ext;
	pid_word_t  d_ext;

	pid_word_t  e_cur;        // e[n]
	pid_word_t  e_prev1;      // e[n-1]
	pid_word_t  e_prev2;      // e[n-2]
	pid_word_t  k1;           // p + i + d
	pid_word_t  k2;           // -p - 2d
	pid_word_t  k3;           // d
	pid_word_t  delta_u;      // output increment
	pid_word_t  u_prev;       // last output
	pid_word_t  u_cur;        // this output

	pid_state_t state;        // current state
	pid_state_t next_state;   // next state
	logic [7:0] cnt;          // cycles spent in current state

	assign core_rst = pid_reset || !lock_en;

	////////////////////////////////////////////////////////////////////////
	// incremental pid law, wraps at core width
	////////////////////////////////////////////////////////////////////////

	assign sp_ext  = pid_word_t'(act.setpoint);  // sign extend
	assign p_ext   = pid_word_t'(act.p);
	assign i_ext   = pid_word_t'(act.i);
	assign d_ext   = pid_word_t'(act.d);

	assign e_cur   = sp_ext - data_q;
	assign k1      = p_ext + i_ext + d_ext;
	assign k2      = -p_ext - (d_ext <<< 1);
	assign k3      = d_ext;
	assign delta_u = k1 * e_cur + k2 * e_prev1 + k3 * e_prev2;
	assign u_cur   = delta_u + u_prev;

	assign pid_data  = u_cur;
	assign pid_valid = (state == SEND);

	////////////////////////////////////////////////////////////////////////
	// registers
	////////////////////////////////////////////////////////////////////////

	// sample only taken while idle, later ones are dropped
	always_ff @(posedge clk_in) begin
		if (data_valid && state == IDLE) begin
			data_q <= data;
		end
	end

	always_ff @(posedge clk_in) begin
		if (core_rst || clear) begin
			u_prev  <= '0;
			e_prev1 <= '0;
			e_prev2 <= '0;
		end else if (state == DONE) begin
			u_prev  <= u_cur;    // accumulate output
			e_prev1 <= e_cur;    // shift error history
			e_prev2 <= e_prev1;
		end
	end

	always_ff @(posedge clk_in) begin
		if (core_rst) begin
			act <= '0;  // relock starts from zero gains
		end else if (update && update_en) begin
			act.setpoint <= setpoint;
			act.p        <= p_coef;
			act.i        <= i_coef;
			act.d        <= d_coef;
		end
	end

	////////////////////////////////////////////////////////////////////////
	// FSM
	////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk_in) begin
		if (core_rst) begin
			state <= IDLE;
			cnt   <= '0;
		end else begin
			state <= next_state;
			if (state != next_state) begin
				cnt <= '0;  // restart on entry
			end else begin
				cnt <= cnt + 1'b1;
			end
		end
	end

	always_comb begin
		next_state = state;
		case (state)
			IDLE:    if (data_valid) next_state = COMPUTE;
			COMPUTE: if (cnt == COMP_LAST) next_state = SEND;
			SEND:    next_state = DONE;
			DONE:    next_state = IDLE;
			default: next_state = IDLE;  // unused codes recover
		endcase
	end

	////////////////////////////////////////////////////////////////////////
	// checks
	////////////////////////////////////////////////////////////////////////

	// filter block rate must leave the core time to finish
	assert property (@(posedge clk_in) disable iff (core_rst)
		data_valid |-> state == IDLE)
	else $error("filtered sample dropped, pid core busy");

endmodule

/* src/pid_ctrl_pkg.sv */
package pid_ctrl_pkg;

	////////////////////////////////////////////////////////////////////////
	// front panel parameters
	////////////////////////////////////////////////////////////////////////

	typedef logic signed [15:0] coef_t;  // setpoint or gain, signed 16 bit

	typedef struct packed {
		coef_t setpoint;  // lock setpoint
		coef_t p;         // proportional gain
		coef_t i;         // integral gain
		coef_t d;         // derivative gain
	} param_set_t;

	////////////////////////////////////////////////////////////////////////
	// core sequencing and output select
	////////////////////////////////////////////////////////////////////////

	typedef enum logic [2:0] {
		IDLE    = 3'd0,  // wait for a filtered sample
		COMPUTE = 3'd1,  // arithmetic settles
		SEND    = 3'd2,  // result valid downstream
		DONE    = 3'd3   // shift error history
	} pid_state_t;

	typedef enum logic {
		PID     = 1'b0,  // core result to dac
		MONITOR = 1'b1   // filtered input to dac
	} src_sel_t;

endpackage

/* src/pid_data_pkg.sv */
`include "pid_config.svh"

package pid_data_pkg;

	////////////////////////////////////////////////////////////////////////
	// data path words
	////////////////////////////////////////////////////////////////////////

	// raw adc sample, two's complement
	typedef logic signed [`PID_W_IN-1:0]  adc_sample_t;

	// filter average and core arithmetic share this width
	typedef logic signed [`PID_W_OUT-1:0] pid_word_t;

	// saturated word for the dac port
	typedef logic signed [`PID_W_DAC-1:0] dac_word_t;

endpackage

/* src/pid_lock_top.sv */
`timescale 1ns/10ps

module pid_lock_top
	import pid_data_pkg::*;
	import pid_ctrl_pkg::*;
(
	input  logic        clk_in,       // system clock
	input  logic        pid_reset,    // sync reset, active high

	input  adc_sample_t adc_data,     // adc sample
	input  logic        adc_valid,    // adc strobe

	input  logic        param_req,    // host handshake
	input  coef_t       setpoint_in,
	input  coef_t       p_coef_in,
	input  coef_t       i_coef_in,
	input  coef_t       d_coef_in,
	output logic        param_ack,

	input  logic        lock_en,      // core enable
	input  logic        clear,        // core history clear
	input  logic        update_en,    // arms update
	input  logic        update,       // param load pulse
	input  src_sel_t    src_sel,      // dac source

	output dac_word_t   dac_data,     // dac word
	output logic        dac_valid     // dac strobe
);

	////////////////////////////////////////////////////////////////////////
	// interconnect
	////////////////////////////////////////////////////////////////////////

	pid_word_t avg_data;      // filter -> core, mux
	logic      avg_valid;
	pid_word_t pid_data;      // core -> mux
	logic      pid_valid;
	coef_t     stg_setpoint;  // param block -> core
	coef_t     stg_p;
	coef_t     stg_i;
	coef_t     stg_d;

	oversample_filter i_filter (
		.clk_in    (clk_in),
		.pid_reset (pid_reset),
		.adc_data  (adc_data),
		.adc_valid (adc_valid),
		.avg_data  (avg_data),
		.avg_valid (avg_valid)
	);

	param_regs i_params (
		.clk_in       (clk_in),
		.pid_reset    (pid_reset),
		.param_req    (param_req),
		.setpoint_in  (setpoint_in),
		.p_coef_in    (p_coef_in),
		.i_coef_in    (i_coef_in),
		.d_coef_in    (d_coef_in),
		.param_ack    (param_ack),
		.stg_setpoint (stg_setpoint),
		.stg_p        (stg_p),
		.stg_i        (stg_i),
		.stg_d        (stg_d)
	);

	pid_core i_core (
		.clk_in     (clk_in),
		.pid_reset  (pid_reset),
		.data       (avg_data),
		.data_valid (avg_valid),
		.setpoint   (stg_setpoint),
		.p_coef     (stg_p),
		.i_coef     (stg_i),
		.d_coef     (stg_d),
		.lock_en    (lock_en),
		.clear      (clear),
		.update_en  (update_en),
		.update     (update),
		.pid_data   (pid_data),
		.pid_valid  (pid_valid)
	);

	source_mux i_mux (
		.clk_in    (clk_in),
		.pid_reset (pid_reset),
		.src_sel   (src_sel),
		.pid_data  (pid_data),
		.pid_valid (pid_valid),
		.avg_data  (avg_data),
		.avg_valid (avg_valid),
		.dac_data  (dac_data),
		.dac_valid (dac_valid)
	);

endmodule

/* src/source_mux.sv */
`timescale 1ns/10ps
`include "pid_config.svh"

module source_mux
	import pid_data_pkg::*;
	import pid_ctrl_pkg::*;
(
	input  logic      clk_in,     // system clock
	input  logic      pid_reset,  // sync reset, active high

	input  src_sel_t  src_sel,    // PID or MONITOR

	input  pid_word_t pid_data,   // core result
	input  logic      pid_valid,  // core strobe
	input  pid_word_t avg_data,   // filtered input
	input  logic      avg_valid,  // filter strobe

	output dac_word_t dac_data,   // saturated dac word
	output logic      dac_valid   // dac strobe
);

	////////////////////////////////////////////////////////////////////////
	// select and clamp
	////////////////////////////////////////////////////////////////////////

	localparam pid_word_t DAC_MAX = (32'sd1 <<< (`PID_W_DAC - 1)) - 32'sd1;  // 16'h7fff
	localparam pid_word_t DAC_MIN = -(32'sd1 <<< (`PID_W_DAC - 1));          // 16'h8000

	pid_word_t sel_data;   // chosen source word
	logic      sel_valid;  // chosen source strobe
	dac_word_t sat_data;   // clamped to dac range

	assign sel_data  = (src_sel == MONITOR) ? avg_data : pid_data;
	assign sel_valid = (src_sel == MONITOR) ? avg_valid : pid_valid;

	always_comb begin
		if (sel_data > DAC_MAX) begin
			sat_data = dac_word_t'(DAC_MAX);  // positive rail
		end else if (sel_data < DAC_MIN) begin
			sat_data = dac_word_t'(DAC_MIN);  // negative rail
		end else begin
			sat_data = dac_word_t'(sel_data);  // in range, drop upper bits
		end
	end

	////////////////////////////////////////////////////////////////////////
	// output register
	////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk_in) begin
		if (pid_reset) begin
			dac_valid <= 1'b0;
		end else begin
			dac_valid <= sel_valid;
		end
	end

	always_ff @(posedge clk_in) begin
		if (sel_valid) begin
			dac_data <= sat_data;  // held between strobes
		end
	end

endmodule

/* tests/tb_pid_lock.sv */
`timescale 1ns/10ps
`include "pid_config.svh"

module tb_pid_lock
	import pid_data_pkg::*;
	import pid_ctrl_pkg::*;
();

	//////////////////////////////////////////////////////////////////////
	// DUT signals
	//////////////////////////////////////////////////////////////////////

	localparam int WAIT_LIMIT = 16;                 // cycles per bounded wait
	localparam int BLOCK_LEN  = 1 << `PID_OS_LOG2;  // samples per block
	localparam int DAC_HI     = (1 << (`PID_W_DAC - 1)) - 1;
	localparam int DAC_LO     = -(1 << (`PID_W_DAC - 1));

	logic        clk_in = 1'b0;
	logic        pid_reset;
	adc_sample_t adc_data;
	logic        adc_valid;
	logic        param_req;
	coef_t       setpoint_in;
	coef_t       p_coef_in;
	coef_t       i_coef_in;
	coef_t       d_coef_in;
	logic        param_ack;
	logic        lock_en;
	logic        clear;
	logic        update_en;
	logic        update;
	src_sel_t    src_sel;
	dac_word_t   dac_data;
	logic        dac_valid;

	always #2 clk_in = ~clk_in;  // 4 ns period

	pid_lock_top i_dut (.*);

	//////////////////////////////////////////////////////////////////////
	// model state and error counts
	//////////////////////////////////////////////////////////////////////

	logic [31:0] rng;         // xorshift state
	int          n_dac_err;
	int          n_ack_err;
	int          n_lat_err;
	int          n_misc_err;  // timeouts, stray strobes
	coef_t       stg_sp;      // values the host last transferred
	coef_t       stg_p;
	coef_t       stg_i;
	coef_t       stg_d;
	int          act_sp;      // active set inside the core
	int          act_p;
	int          act_i;
	int          act_d;
	int          e1;          // e[n-1]
	int          e2;          // e[n-2]
	int          u_prev;      // last core output, wraps at 32 bits
	logic        lock_on;
	dac_word_t   last_dac;    // last word seen on the dac port

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	function automatic dac_word_t saturate(input int v);
		if (v > DAC_HI) return dac_word_t'(DAC_HI);  // positive rail
		if (v < DAC_LO) return dac_word_t'(DAC_LO);  // negative rail
		return dac_word_t'(v);
	endfunction

	task automatic roll(output logic [31:0] r);
		rng = xorshift32(rng);
		r   = rng;
	endtask

	task automatic roll_coef(input int shift, output coef_t c);
		logic [31:0] r;
		roll(r);
		c = coef_t'($signed(r[15:0]) >>> shift);  // shift narrows the range
	endtask

	//////////////////////////////////////////////////////////////////////
	// compare tasks
	//////////////////////////////////////////////////////////////////////

	task automatic check_dac(input string name, input dac_word_t expected,
		input dac_word_t actual);
		if (actual !== expected) begin
			$display("Fail %s: expected %h, actual %h", name, expected, actual);
			n_dac_err++;
		end
	endtask

	task automatic check_ack(input string name, input logic expected, input logic actual);
		if (actual !== expected) begin
			$display("Fail %s: expected %b, actual %b", name, expected, actual);
			n_ack_err++;
		end
	endtask

	task automatic check_latency(input string name, input int expected, input int actual);
		if (actual != expected) begin
			$display("Fail %s latency: expected %0d, actual %0d", name, expected, actual);
			n_lat_err++;
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// stimulus tasks
	//////////////////////////////////////////////////////////////////////

	task automatic tick();
		@(posedge clk_in);
		#1;  // drive and sample clear of the edge
	endtask

	task automatic idle(input int n);
		repeat (n) tick();
	endtask

	// four phase transfer to the staging registers
	task automatic host_write(input coef_t sp, input coef_t p, input coef_t i, input coef_t d);
		int          t;
		logic [31:0] r;
		check_ack("ack low before req", 1'b0, param_ack);
		setpoint_in = sp;
		p_coef_in   = p;
		i_coef_in   = i;
		d_coef_in   = d;
		param_req   = 1'b1;
		t = 0;
		while (!param_ack && t < WAIT_LIMIT) begin
			tick();
			t++;
		end
		if (!param_ack) begin
			$display("Timeout: param_ack did not rise within %0d cycles", WAIT_LIMIT);
			n_misc_err++;
		end
		idle(2);
		check_ack("ack held while req high", 1'b1, param_ack);
		param_req = 1'b0;
		t = 0;
		while (param_ack && t < WAIT_LIMIT) begin
			tick();
			t++;
		end
		if (param_ack) begin
			$display("Timeout: param_ack did not fall within %0d cycles", WAIT_LIMIT);
			n_misc_err++;
		end
		roll(r);  // bus free again, junk must not reach the staging regs
		setpoint_in = coef_t'(r[15:0]);
		p_coef_in   = coef_t'(r[31:16]);
		i_coef_in   = coef_t'(r[23:8]);
		d_coef_in   = coef_t'(~r[15:0]);
		stg_sp = sp;
		stg_p  = p;
		stg_i  = i;
		stg_d  = d;
	endtask

	task automatic host_random(input int k_shift);
		coef_t sp;
		coef_t p;
		coef_t i;
		coef_t d;
		roll_coef(6, sp);  // setpoint within +-512
		roll_coef(k_shift, p);
		roll_coef(k_shift, i);
		roll_coef(k_shift, d);
		host_write(sp, p, i, d);
	endtask

	task automatic pulse_update(input logic en);
		tick();
		update_en = en;
		update    = 1'b1;
		tick();
		update    = 1'b0;
		update_en = 1'b0;
		if (en) begin  // gated copy of the staged set
			act_sp = int'(stg_sp);
			act_p  = int'(stg_p);
			act_i  = int'(stg_i);
			act_d  = int'(stg_d);
		end
	endtask

	task automatic pulse_clear();
		tick();
		clear = 1'b1;
		tick();
		clear  = 1'b0;
		e1     = 0;
		e2     = 0;
		u_prev = 0;
	endtask

	task automatic set_lock(input logic on);
		tick();
		lock_en = on;
		lock_on = on;
		if (!on) begin  // core held in reset, gains and history gone
			act_sp = 0;
			act_p  = 0;
			act_i  = 0;
			act_d  = 0;
			e1     = 0;
			e2     = 0;
			u_prev = 0;
		end
		tick();
	endtask

	// one block of samples with random gaps, then the dac result
	task automatic run_block(input string name, input int shift);
		logic [31:0] r;
		adc_sample_t smp;
		int          n;
		int          sum;
		int          avg;
		int          e;
		int          u;
		int          lat;
		int          exp_lat;
		logic        want;
		logic        seen;
		dac_word_t   exp_dac;
		sum = 0;
		u   = 0;
		for (n = 0; n < BLOCK_LEN; n++) begin
			roll(r);
			smp = adc_sample_t'($signed(r[17:0]) >>> shift);
			repeat (r[31:30]) begin  // 0 to 3 idle cycles
				tick();
				adc_valid = 1'b0;
			end
			tick();
			adc_data  = smp;
			adc_valid = 1'b1;
			sum += int'(smp);
		end
		avg = sum >>> `PID_OS_LOG2;  // block average, rounds down
		// core takes every block while locked, whatever the source
		if (lock_on) begin
			e = act_sp - avg;
			u = (act_p + act_i + act_d) * e     // k1 * e[n]
				+ (-act_p - 2 * act_d) * e1     // k2 * e[n-1]
				+ act_d * e2 + u_prev;          // k3 * e[n-2] plus last output
			u_prev = u;
			e2     = e1;
			e1     = e;
		end
		if (src_sel == MONITOR) begin
			want    = 1'b1;
			exp_dac = saturate(avg);
			exp_lat = 2;  // avg_valid then mux register
		end else begin
			want    = lock_on;
			exp_dac = saturate(u);
			exp_lat = `PID_COMP_LATENCY + 3;  // avg_valid plus COMP_LATENCY + 2
		end
		lat  = 0;
		seen = 1'b0;
		while (!seen && lat < WAIT_LIMIT) begin
			tick();
			adc_valid = 1'b0;
			lat++;
			seen = dac_valid;
		end
		if (!want && seen) begin
			$display("dac_valid appeared while lock_en was low in %s", name);
			n_misc_err++;
		end else if (want && !seen) begin
			$display("Timeout: no dac_valid within %0d cycles in %s", WAIT_LIMIT, name);
			n_misc_err++;
		end else if (want) begin
			check_latency(name, exp_lat, lat);
			check_dac(name, exp_dac, dac_data);
			last_dac = dac_data;
		end
		idle(4);  // core back in IDLE before anything else moves
	endtask

	//////////////////////////////////////////////////////////////////////
	// test sequence
	//////////////////////////////////////////////////////////////////////

	initial begin
		rng        = 32'h320e3da1;
		n_dac_err  = 0;
		n_ack_err  = 0;
		n_lat_err  = 0;
		n_misc_err = 0;
		stg_sp = '0;
		stg_p  = '0;
		stg_i  = '0;
		stg_d  = '0;
		act_sp = 0;
		act_p  = 0;
		act_i  = 0;
		act_d  = 0;
		e1     = 0;
		e2     = 0;
		u_prev = 0;
		lock_on  = 1'b1;
		last_dac = '0;
		pid_reset   = 1'b1;
		adc_data    = '0;
		adc_valid   = 1'b0;
		param_req   = 1'b0;
		setpoint_in = '0;
		p_coef_in   = '0;
		i_coef_in   = '0;
		d_coef_in   = '0;
		lock_en     = 1'b1;
		clear       = 1'b0;
		update_en   = 1'b0;
		update      = 1'b0;
		src_sel     = MONITOR;
		idle(5);
		pid_reset = 1'b0;
		check_ack("ack after reset", 1'b0, param_ack);
		if (dac_valid !== 1'b0) begin
			$display("dac_valid was high right after reset");
			n_misc_err++;
		end

		// monitor path, full range then narrow
		repeat (6) run_block("monitor full", 0);
		repeat (6) run_block("monitor narrow", 3);

		// staged values stay inert until the update pulse
		src_sel = PID;
		host_random(13);
		repeat (3) run_block("staged no update", 8);
		pulse_update(1'b1);

		// pid law, gains refreshed every few blocks
		for (int k = 0; k < 24; k++) begin
			if (k % 6 == 5) begin
				host_random(13);
				pulse_update(1'b1);
			end
			run_block("pid law", 8);
		end

		// update without update_en keeps the old gains
		host_random(13);
		pulse_update(1'b0);
		repeat (4) run_block("update gated", 8);
		pulse_update(1'b1);
		repeat (2) run_block("update armed", 8);

		// clear, unlock, relock
		pulse_clear();
		run_block("after clear", 8);
		set_lock(1'b0);
		repeat (2) run_block("unlocked", 8);
		set_lock(1'b1);
		run_block("relock zero gains", 8);
		check_dac("relock output zero", '0, last_dac);
		pulse_update(1'b1);
		repeat (3) run_block("relock updated", 8);

		// rails, inputs near zero
		pulse_clear();
		host_write(16'sh7fff, 16'sd1000, 16'sd0, 16'sd0);
		pulse_update(1'b1);
		repeat (2) begin
			run_block("saturation high", 17);
			check_dac("saturation high rail", 16'sh7fff, last_dac);
		end
		host_write(16'sh8000, 16'sd1000, 16'sd0, 16'sd0);
		pulse_update(1'b1);
		run_block("saturation low", 17);
		check_dac("saturation low rail", 16'sh8000, last_dac);

		$display("errors: dac %0d, ack %0d, latency %0d, other %0d",
			n_dac_err, n_ack_err, n_lat_err, n_misc_err);
		if (n_dac_err + n_ack_err + n_lat_err + n_misc_err == 0) begin
			$display("TEST PASS");
		end else begin
			$display("TEST FAIL");
		end
		$finish;
	end

endmodule
